//--- hdl/decode_pkg.sv
// ####################
// shared sizes, prefix and opcode byte codes
// segment numbers, opcode classes and the
// per-byte prefix classification record
// ####################

package decode_pkg;

  // fetch window and prefix scan sizes
  localparam int window_bytes = 16;
  localparam int max_prefix = 4;

  typedef logic [31:0] eip_t;
  // lengths never exceed 15 bytes
  typedef logic [3:0] len_t;

  // prefix bytes recognised in the leading positions
  localparam logic [7:0] pfx_repne = 8'hF2;
  localparam logic [7:0] pfx_cs = 8'h2E;
  localparam logic [7:0] pfx_ss = 8'h36;
  localparam logic [7:0] pfx_ds = 8'h3E;
  localparam logic [7:0] pfx_es = 8'h26;
  localparam logic [7:0] pfx_fs = 8'h64;
  localparam logic [7:0] pfx_gs = 8'h65;
  localparam logic [7:0] pfx_size = 8'h66;
  localparam logic [7:0] pfx_0f = 8'h0F;

  // x86 segment register numbering
  typedef enum logic [2:0] {
    seg_es = 3'd0,
    seg_cs = 3'd1,
    seg_ss = 3'd2,
    seg_ds = 3'd3,
    seg_fs = 3'd4,
    seg_gs = 3'd5
  } seg_reg_e;

  localparam logic [7:0] opc_hlt = 8'hF4;
  localparam logic [7:0] opc_iret = 8'hCF;

  // operand layout following the opcode byte
  typedef enum logic [2:0] {
    op_none,
    op_imm8,
    op_immv,
    op_modrm,
    op_modrm_imm8,
    op_modrm_immv,
    op_unknown
  } op_class_e;

  // one window byte seen as a prefix, seg_hit indexed by seg_reg_e
  typedef struct packed {
    logic       any;
    logic       repne;
    logic       size_over;
    logic       two_byte;
    logic [5:0] seg_hit;
  } prefix_hit_t;

endpackage

//--- hdl/decode_ifs.sv
// ####################
// window_if  stage-1 window with prefix summary
// field_if   extracted fields ahead of stage 2
// ####################

`timescale 1ns/1ps

interface window_if;
  logic                                 valid;
  logic [8*decode_pkg::window_bytes-1:0] bytes;
  logic [decode_pkg::window_bytes-1:0]  byte_valids;
  decode_pkg::eip_t                     eip;
  // 0 to 4 leading prefixes
  logic [2:0]                           pfx_count;
  logic                                 repne;
  logic                                 size_over;
  logic                                 two_byte;
  logic                                 seg_over;
  decode_pkg::seg_reg_e                 seg_reg;

  modport src (output valid, bytes, byte_valids, eip, pfx_count, repne, size_over,
               two_byte, seg_over, seg_reg);
  modport dst (input valid, bytes, byte_valids, eip, pfx_count, repne, size_over,
               two_byte, seg_over, seg_reg);
endinterface

interface field_if;
  logic                                valid;
  logic [7:0]                          opcode;
  logic [7:0]                          modrm;
  logic [7:0]                          sib;
  logic                                sib_pr;
  logic [31:0]                         disp32;
  logic [31:0]                         imm32;
  decode_pkg::len_t                    inst_len;
  decode_pkg::eip_t                    eip;
  logic [decode_pkg::window_bytes-1:0] byte_valids;
  logic                                repne;
  logic                                size_over;
  logic                                two_byte;
  logic                                seg_over;
  decode_pkg::seg_reg_e                seg_reg;
  logic                                hlt;
  logic                                iret;
  logic                                invalid_op;

  modport src (output valid, opcode, modrm, sib, sib_pr, disp32, imm32, inst_len, eip,
               byte_valids, repne, size_over, two_byte, seg_over, seg_reg, hlt, iret,
               invalid_op);
  modport dst (input valid, opcode, modrm, sib, sib_pr, disp32, imm32, inst_len, eip,
               byte_valids, repne, size_over, two_byte, seg_over, seg_reg, hlt, iret,
               invalid_op);
endinterface

//--- hdl/prefix_byte_classify.sv
// ####################
// prefix_byte_classify
// matches one window byte against the prefix codes
// ####################

`timescale 1ns/1ps

module prefix_byte_classify (
  input  logic [7:0]              byte_in,
  output decode_pkg::prefix_hit_t hit
);

  always_comb begin
    hit = '0;
    hit.repne = (byte_in == decode_pkg::pfx_repne);
    hit.size_over = (byte_in == decode_pkg::pfx_size);
    hit.two_byte = (byte_in == decode_pkg::pfx_0f);
    // segment overrides land on their register number
    hit.seg_hit[decode_pkg::seg_es] = (byte_in == decode_pkg::pfx_es);
    hit.seg_hit[decode_pkg::seg_cs] = (byte_in == decode_pkg::pfx_cs);
    hit.seg_hit[decode_pkg::seg_ss] = (byte_in == decode_pkg::pfx_ss);
    hit.seg_hit[decode_pkg::seg_ds] = (byte_in == decode_pkg::pfx_ds);
    hit.seg_hit[decode_pkg::seg_fs] = (byte_in == decode_pkg::pfx_fs);
    hit.seg_hit[decode_pkg::seg_gs] = (byte_in == decode_pkg::pfx_gs);
    hit.any = hit.repne | hit.size_over | hit.two_byte | (|hit.seg_hit);
  end

endmodule

//--- hdl/prefix_merge.sv
// ####################
// prefix_merge
// thermometer mask over the classified bytes,
// prefix summary and the stage-1 register
// ####################

`timescale 1ns/1ps

module prefix_merge (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  in_valid,
  input  logic [8*decode_pkg::window_bytes-1:0] ic_bytes,
  input  logic [decode_pkg::window_bytes-1:0]   byte_valids,
  input  decode_pkg::eip_t                      eip,
  input  decode_pkg::prefix_hit_t               hits [decode_pkg::max_prefix],
  window_if.src                                 win
);

  logic [decode_pkg::max_prefix-1:0] therm;
  logic [2:0]                        pfx_cnt;
  logic                              repne_c;
  logic                              size_c;
  logic                              two_byte_c;
  logic [5:0]                        seg_any;
  decode_pkg::seg_reg_e              seg_reg_c;

  // a position counts only while every byte before it was a prefix too
  always_comb begin
    therm[0] = hits[0].any;
    for (int i = 1; i < decode_pkg::max_prefix; i++) begin
      therm[i] = therm[i-1] & hits[i].any;
    end
  end

  always_comb begin
    pfx_cnt = '0;
    repne_c = 1'b0;
    size_c = 1'b0;
    two_byte_c = 1'b0;
    seg_any = '0;
    for (int i = 0; i < decode_pkg::max_prefix; i++) begin
      pfx_cnt = pfx_cnt + 3'(therm[i]);
      repne_c = repne_c | (therm[i] & hits[i].repne);
      size_c = size_c | (therm[i] & hits[i].size_over);
      two_byte_c = two_byte_c | (therm[i] & hits[i].two_byte);
      seg_any = seg_any | ({6{therm[i]}} & hits[i].seg_hit);
    end
  end

  // es wins over cs over ss ... gs, ds when no override
  always_comb begin
    seg_reg_c = decode_pkg::seg_ds;
    for (int s = 5; s >= 0; s--) begin
      if (seg_any[s]) begin
        seg_reg_c = decode_pkg::seg_reg_e'(s);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      win.valid <= 1'b0;
    end else begin
      win.valid <= in_valid;
    end
  end

  // stage-1 payload
  always_ff @(posedge clk) begin
    if (in_valid) begin
      win.bytes <= ic_bytes;
      win.byte_valids <= byte_valids;
      win.eip <= eip;
      win.pfx_count <= pfx_cnt;
      win.repne <= repne_c;
      win.size_over <= size_c;
      win.two_byte <= two_byte_c;
      win.seg_over <= |seg_any;
      win.seg_reg <= seg_reg_c;
    end
  end

endmodule

//--- hdl/opcode_attr_rom.sv
// ####################
// opcode_attr_rom
// small opcode table giving ModRM presence,
// immediate size and the hlt / iret marks
// ####################

`timescale 1ns/1ps

module opcode_attr_rom (
  input  logic [7:0] opcode,
  input  logic       size_over,
  output logic       has_modrm,
  output logic [2:0] imm_bytes,
  output logic       known,
  output logic       is_hlt,
  output logic       is_iret
);

  decode_pkg::op_class_e op_class;
  logic [2:0]            immv_bytes;

  always_comb begin
    case (opcode) inside
      8'h90, 8'hC3, 8'hCF, 8'hF4:                op_class = decode_pkg::op_none;
      8'h04, 8'h6A, 8'hEB, 8'h74, 8'h75:         op_class = decode_pkg::op_imm8;
      8'h05, 8'h68, 8'hE8, 8'hE9, [8'hB8:8'hBF]: op_class = decode_pkg::op_immv;
      8'h01, 8'h03, 8'h29, 8'h31, 8'h89, 8'h8B:  op_class = decode_pkg::op_modrm;
      8'h83, 8'hC6:                              op_class = decode_pkg::op_modrm_imm8;
      8'h81, 8'hC7:                              op_class = decode_pkg::op_modrm_immv;
      default:                                   op_class = decode_pkg::op_unknown;
    endcase
  end

  // word immediates shrink to 16 bits under 66
  assign immv_bytes = size_over ? 3'd2 : 3'd4;

  always_comb begin
    has_modrm = 1'b0;
    imm_bytes = 3'd0;
    known = 1'b1;
    case (op_class)
      decode_pkg::op_imm8:       imm_bytes = 3'd1;
      decode_pkg::op_immv:       imm_bytes = immv_bytes;
      decode_pkg::op_modrm:      has_modrm = 1'b1;
      decode_pkg::op_modrm_imm8: begin
        has_modrm = 1'b1;
        imm_bytes = 3'd1;
      end
      decode_pkg::op_modrm_immv: begin
        has_modrm = 1'b1;
        imm_bytes = immv_bytes;
      end
      decode_pkg::op_unknown:    known = 1'b0;
      default:                   known = 1'b1;
    endcase
  end

  assign is_hlt = (opcode == decode_pkg::opc_hlt);
  assign is_iret = (opcode == decode_pkg::opc_iret);

endmodule

//--- hdl/field_extract.sv
// ####################
// field_extract
// opcode, ModRM, SIB, displacement and immediate
// selection plus the instruction length
// ####################

`timescale 1ns/1ps

module field_extract (
  window_if.dst win,
  field_if.src  fld
);

  // four zero bytes above the window keep wide reads in range
  logic [8*(decode_pkg::window_bytes+4)-1:0] padded;
  logic [3:0]  opc_pos;
  logic [3:0]  disp_pos;
  logic [3:0]  imm_pos;
  logic [7:0]  opc_byte;
  logic [7:0]  modrm_byte;
  logic [7:0]  sib_byte;
  logic [1:0]  modrm_mod;
  logic [2:0]  modrm_rm;
  logic        has_modrm;
  logic [2:0]  imm_bytes;
  logic        known;
  logic        is_hlt;
  logic        is_iret;
  logic        sib_pr_c;
  logic [2:0]  disp_bytes;
  logic [31:0] disp_raw;
  logic [31:0] imm_raw;

  assign padded = {32'h0, win.bytes};

  // opcode sits right after the counted prefixes
  assign opc_pos = {1'b0, win.pfx_count};
  assign opc_byte = padded[8*opc_pos +: 8];
  assign modrm_byte = padded[8*(opc_pos + 4'd1) +: 8];
  assign sib_byte = padded[8*(opc_pos + 4'd2) +: 8];

  opcode_attr_rom u_attr (
    .opcode    (opc_byte),
    .size_over (win.size_over),
    .has_modrm (has_modrm),
    .imm_bytes (imm_bytes),
    .known     (known),
    .is_hlt    (is_hlt),
    .is_iret   (is_iret)
  );

  assign modrm_mod = modrm_byte[7:6];
  assign modrm_rm = modrm_byte[2:0];
  assign sib_pr_c = has_modrm && (modrm_mod != 2'b11) && (modrm_rm == 3'b100);

  // 32-bit addressing displacement size
  always_comb begin
    disp_bytes = 3'd0;
    if (has_modrm) begin
      case (modrm_mod)
        2'b01: disp_bytes = 3'd1;
        2'b10: disp_bytes = 3'd4;
        2'b00: begin
          if (modrm_rm == 3'b101 || (sib_pr_c && sib_byte[2:0] == 3'b101)) begin
            disp_bytes = 3'd4;
          end
        end
        default: disp_bytes = 3'd0;
      endcase
    end
  end

  assign disp_pos = opc_pos + 4'd2 + {3'b0, sib_pr_c};
  assign imm_pos = opc_pos + 4'd1 + {3'b0, has_modrm} + {3'b0, sib_pr_c}
                   + {1'b0, disp_bytes};
  assign disp_raw = padded[8*disp_pos +: 32];
  assign imm_raw = padded[8*imm_pos +: 32];

  always_comb begin
    case (disp_bytes)
      3'd1:    fld.disp32 = {{24{disp_raw[7]}}, disp_raw[7:0]};
      3'd4:    fld.disp32 = disp_raw;
      default: fld.disp32 = '0;
    endcase
    case (imm_bytes)
      3'd1:    fld.imm32 = {{24{imm_raw[7]}}, imm_raw[7:0]};
      3'd2:    fld.imm32 = {16'h0, imm_raw[15:0]};
      3'd4:    fld.imm32 = imm_raw;
      default: fld.imm32 = '0;
    endcase
  end

  assign fld.valid = win.valid;
  assign fld.opcode = opc_byte;
  assign fld.modrm = has_modrm ? modrm_byte : 8'h00;
  // SIB byte reported only when one is present
  assign fld.sib = sib_pr_c ? sib_byte : 8'h00;
  assign fld.sib_pr = sib_pr_c;
  // immediate is the last field, so its end is the length
  assign fld.inst_len = imm_pos + {1'b0, imm_bytes};
  assign fld.eip = win.eip;
  assign fld.byte_valids = win.byte_valids;
  assign fld.repne = win.repne;
  assign fld.size_over = win.size_over;
  assign fld.two_byte = win.two_byte;
  assign fld.seg_over = win.seg_over;
  assign fld.seg_reg = win.seg_reg;
  assign fld.hlt = is_hlt;
  assign fld.iret = is_iret;
  assign fld.invalid_op = ~known;

endmodule

//--- hdl/decode_result_stage.sv
// ####################
// decode_result_stage
// next EIP, fetch exception check and
// the stage-2 output register
// ####################

`timescale 1ns/1ps

module decode_result_stage (
  input  logic                 clk,
  input  logic                 reset,
  field_if.dst                 fld,
  output logic                 out_valid,
  output logic [7:0]           opcode,
  output logic [7:0]           modrm,
  output logic [7:0]           sib,
  output logic                 sib_pr,
  output logic [31:0]          disp32,
  output logic [31:0]          imm32,
  output decode_pkg::len_t     inst_len,
  output decode_pkg::eip_t     eip_next,
  output logic                 repne,
  output logic                 size_over,
  output logic                 two_byte,
  output logic                 seg_over,
  output decode_pkg::seg_reg_e seg_reg,
  output logic                 hlt,
  output logic                 iret,
  output logic                 invalid_op,
  output logic                 ic_exp
);

  logic [decode_pkg::window_bytes-1:0] in_inst;
  decode_pkg::eip_t                    eip_next_c;
  logic                                ic_exp_c;

  // 32-bit add wraps past FFFFFFFF on its own
  assign eip_next_c = fld.eip + decode_pkg::eip_t'(fld.inst_len);

  // bytes covered by the instruction
  always_comb begin
    for (int i = 0; i < decode_pkg::window_bytes; i++) begin
      in_inst[i] = (i < fld.inst_len);
    end
  end

  assign ic_exp_c = |(in_inst & ~fld.byte_valids);

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= fld.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (fld.valid) begin
      opcode <= fld.opcode;
      modrm <= fld.modrm;
      sib <= fld.sib;
      sib_pr <= fld.sib_pr;
      disp32 <= fld.disp32;
      imm32 <= fld.imm32;
      inst_len <= fld.inst_len;
      eip_next <= eip_next_c;
      repne <= fld.repne;
      size_over <= fld.size_over;
      two_byte <= fld.two_byte;
      seg_over <= fld.seg_over;
      seg_reg <= fld.seg_reg;
      hlt <= fld.hlt;
      iret <= fld.iret;
      invalid_op <= fld.invalid_op;
      ic_exp <= ic_exp_c;
    end
  end

endmodule

//--- hdl/decode_top.sv
// ####################
// decode_top
// prefix classifiers, prefix merge (stage 1),
// field extraction and result stage (stage 2)
// ####################

`timescale 1ns/1ps

module decode_top (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  in_valid,
  input  logic [8*decode_pkg::window_bytes-1:0] ic_bytes,
  input  logic [decode_pkg::window_bytes-1:0]   byte_valids,
  input  decode_pkg::eip_t                      eip,
  output logic                                  out_valid,
  output logic [7:0]                            opcode,
  output logic [7:0]                            modrm,
  output logic [7:0]                            sib,
  output logic                                  sib_pr,
  output logic [31:0]                           disp32,
  output logic [31:0]                           imm32,
  output decode_pkg::len_t                      inst_len,
  output decode_pkg::eip_t                      eip_next,
  output logic                                  repne,
  output logic                                  size_over,
  output logic                                  two_byte,
  output logic                                  seg_over,
  output decode_pkg::seg_reg_e                  seg_reg,
  output logic                                  hlt,
  output logic                                  iret,
  output logic                                  invalid_op,
  output logic                                  ic_exp
);

  decode_pkg::prefix_hit_t hits [decode_pkg::max_prefix];

  window_if u_win ();
  field_if  u_fld ();

  // one classifier per candidate prefix position
  for (genvar i = 0; i < decode_pkg::max_prefix; i++) begin : g_pfx
    prefix_byte_classify u_classify (
      .byte_in (ic_bytes[8*i +: 8]),
      .hit     (hits[i])
    );
  end

  prefix_merge u_merge (
    .clk         (clk),
    .reset       (reset),
    .in_valid    (in_valid),
    .ic_bytes    (ic_bytes),
    .byte_valids (byte_valids),
    .eip         (eip),
    .hits        (hits),
    .win         (u_win.src)
  );

  field_extract u_extract (
    .win (u_win.dst),
    .fld (u_fld.src)
  );

  decode_result_stage u_result (
    .clk        (clk),
    .reset      (reset),
    .fld        (u_fld.dst),
    .out_valid  (out_valid),
    .opcode     (opcode),
    .modrm      (modrm),
    .sib        (sib),
    .sib_pr     (sib_pr),
    .disp32     (disp32),
    .imm32      (imm32),
    .inst_len   (inst_len),
    .eip_next   (eip_next),
    .repne      (repne),
    .size_over  (size_over),
    .two_byte   (two_byte),
    .seg_over   (seg_over),
    .seg_reg    (seg_reg),
    .hlt        (hlt),
    .iret       (iret),
    .invalid_op (invalid_op),
    .ic_exp     (ic_exp)
  );

endmodule

//--- test/tb_decode_model.svh
// ####################
// expected result record and decode reference model
// Galois LFSR and instruction window builders
// ####################

`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

typedef struct packed {
  logic [7:0]  opcode;
  logic [7:0]  modrm;
  logic [7:0]  sib;
  logic        sib_pr;
  logic [31:0] disp32;
  logic [31:0] imm32;
  logic [3:0]  inst_len;
  logic [31:0] eip_next;
  logic        repne;
  logic        size_over;
  logic        two_byte;
  logic        seg_over;
  logic [2:0]  seg_reg;
  logic        hlt;
  logic        iret;
  logic        invalid_op;
  logic        ic_exp;
} result_t;

// random choices, entry 0 in the low byte
localparam logic [127:0] op_picks = 128'hFF00_C781_C683_8B01_E8B9_056A_04F4_CF90;
localparam logic [71:0] pfx_picks = 72'h0F_66_65_64_26_3E_36_2E_F2;

logic [15:0] lfsr_state = 16'd53;

// one LFSR step per bit, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int k = 0; k < n; k++) begin
    v = {v[30:0], lfsr_state[0]};
    lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
  end
  return v;
endfunction

// classes: 0 none, 1 imm8, 2 immv, 3 modrm, 4 modrm+imm8, 5 modrm+immv, 6 unknown
function automatic int op_class(input logic [7:0] op);
  case (op) inside
    8'h90, 8'hC3, 8'hCF, 8'hF4: return 0;
    8'h04, 8'h6A, 8'hEB, 8'h74, 8'h75: return 1;
    8'h05, 8'h68, 8'hE8, 8'hE9, [8'hB8:8'hBF]: return 2;
    8'h01, 8'h03, 8'h29, 8'h31, 8'h89, 8'h8B: return 3;
    8'h83, 8'hC6: return 4;
    8'h81, 8'hC7: return 5;
    default: return 6;
  endcase
endfunction

// little-endian field, single bytes sign-extended
function automatic logic [31:0] field_value(input logic [127:0] w, input int pos,
                                            input int nbytes);
  logic [31:0] v;
  v = '0;
  for (int k = 0; k < nbytes; k++) begin
    if (pos + k < 16) v[8*k +: 8] = w[8*(pos+k) +: 8];
  end
  if (nbytes == 1) v = {{24{v[7]}}, v[7:0]};
  return v;
endfunction

function automatic result_t predict(input logic [127:0] w, input logic [15:0] bv,
                                    input logic [31:0] ip);
  result_t    r;
  logic [5:0] segs;
  int         n;
  int         cls;
  int         pos;
  int         dlen;
  int         ilen;
  int         len;
  r = '0;
  segs = '0;
  n = 0;
  // leading run of prefixes, four at most
  for (int i = 0; i < 4; i++) begin
    if (n == i) begin
      n = i + 1;
      case (w[8*i +: 8])
        8'hF2: r.repne = 1'b1;
        8'h66: r.size_over = 1'b1;
        8'h0F: r.two_byte = 1'b1;
        8'h26: segs[0] = 1'b1;
        8'h2E: segs[1] = 1'b1;
        8'h36: segs[2] = 1'b1;
        8'h3E: segs[3] = 1'b1;
        8'h64: segs[4] = 1'b1;
        8'h65: segs[5] = 1'b1;
        default: n = i;
      endcase
    end
  end
  r.seg_over = |segs;
  r.seg_reg = 3'd3;
  for (int s = 5; s >= 0; s--) begin
    if (segs[s]) r.seg_reg = 3'(s);
  end
  r.opcode = w[8*n +: 8];
  cls = op_class(r.opcode);
  ilen = (cls == 1 || cls == 4) ? 1 : (cls == 2 || cls == 5) ? (r.size_over ? 2 : 4) : 0;
  dlen = 0;
  pos = n + 1;
  if (cls >= 3 && cls <= 5) begin
    r.modrm = w[8*pos +: 8];
    r.sib_pr = (r.modrm[7:6] != 2'b11) && (r.modrm[2:0] == 3'b100);
    if (r.sib_pr) r.sib = w[8*(pos+1) +: 8];
    pos = pos + 1 + r.sib_pr;
    case (r.modrm[7:6])
      2'b01: dlen = 1;
      2'b10: dlen = 4;
      2'b00: dlen = (r.modrm[2:0] == 3'b101 || (r.sib_pr && r.sib[2:0] == 3'b101)) ? 4 : 0;
      default: dlen = 0;
    endcase
  end
  r.disp32 = field_value(w, pos, dlen);
  r.imm32 = field_value(w, pos + dlen, ilen);
  len = pos + dlen + ilen;
  r.inst_len = 4'(len);
  r.eip_next = ip + len;
  for (int i = 0; i < 16; i++) begin
    if (i < len && !bv[i]) r.ic_exp = 1'b1;
  end
  r.hlt = (r.opcode == 8'hF4);
  r.iret = (r.opcode == 8'hCF);
  r.invalid_op = (cls == 6);
  return r;
endfunction

// random filler, then prefixes, opcode and the bytes after it
function automatic logic [127:0] make_window(input int npfx, input logic [31:0] pfx,
                                             input logic [7:0] op, input int nbody,
                                             input logic [95:0] body);
  logic [127:0] w;
  for (int k = 0; k < 4; k++) begin
    w[32*k +: 32] = rand_bits(32);
  end
  for (int k = 0; k < npfx; k++) begin
    w[8*k +: 8] = pfx[8*k +: 8];
  end
  w[8*npfx +: 8] = op;
  for (int k = 0; k < nbody && npfx + 1 + k < 16; k++) begin
    w[8*(npfx+1+k) +: 8] = body[8*k +: 8];
  end
  return w;
endfunction

function automatic logic [127:0] rand_window();
  int          npfx;
  logic [31:0] pfx;
  npfx = rand_bits(3) % 5;
  pfx = '0;
  for (int k = 0; k < npfx; k++) begin
    pfx[8*k +: 8] = pfx_picks[8*(rand_bits(4) % 9) +: 8];
  end
  return make_window(npfx, pfx, op_picks[8*rand_bits(4) +: 8], 0, '0);
endfunction

`endif

//--- test/tb_decode_top.sv
// ####################
// testbench for decode_top with clock, reset,
// directed and random instructions,
// expectation queue and output checks
// ####################

`timescale 1ns/1ps

module tb_decode_top;

  `include "tb_decode_model.svh"

  logic                 clk;
  logic                 reset;
  logic                 in_valid;
  logic [127:0]         ic_bytes;
  logic [15:0]          byte_valids;
  logic [31:0]          eip;
  logic                 out_valid, sib_pr, repne, size_over, two_byte, seg_over;
  logic                 hlt, iret, invalid_op, ic_exp;
  logic [7:0]           opcode, modrm, sib;
  logic [31:0]          disp32, imm32;
  decode_pkg::len_t     inst_len;
  decode_pkg::eip_t     eip_next;
  decode_pkg::seg_reg_e seg_reg;

  result_t exp_q[$];
  int      due_q[$];
  int      cycle = 0;
  int      tests = 0;
  int      total_checks = 0;
  int      total_errors = 0;
  int      test_checks = 0;
  int      test_errors = 0;

  decode_top u_dut (.*);

  always #50 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  // outputs sampled mid-cycle away from the clock edge
  always @(negedge clk) begin : check_outputs
    result_t got;
    logic    due;
    due = (due_q.size() > 0) && (due_q[0] == cycle);
    assert (out_valid === due) else begin
      $display("FAIL t=%0t: out_valid is %b, expected %b", $time, out_valid, due);
      test_errors++;
    end
    if (due) begin
      got = {opcode, modrm, sib, sib_pr, disp32, imm32, inst_len, eip_next, repne,
             size_over, two_byte, seg_over, seg_reg, hlt, iret, invalid_op, ic_exp};
      test_checks++;
      assert (got === exp_q[0]) else begin
        $display("FAIL t=%0t: decode mismatch, got %h expected %h", $time, got, exp_q[0]);
        test_errors++;
      end
      exp_q.pop_front();
      due_q.pop_front();
    end
  end

  // sampled at the next edge, result seen after the edge following that one
  task automatic send(input logic [127:0] w, input logic [15:0] bv, input logic [31:0] ip);
    in_valid = 1'b1;
    ic_bytes = w;
    byte_valids = bv;
    eip = ip;
    exp_q.push_back(predict(w, bv, ip));
    due_q.push_back(cycle + 2);
    @(posedge clk);
    #1;
  endtask

  task automatic send_inst(input int npfx, input logic [31:0] pfx, input logic [7:0] op,
                           input int nbody, input logic [95:0] body);
    send(make_window(npfx, pfx, op, nbody, body), 16'hFFFF, rand_bits(32));
  endtask

  task automatic finish_test(input string name);
    int waited;
    in_valid = 1'b0;
    waited = 0;
    while (exp_q.size() > 0 && waited < 10) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (exp_q.size() > 0) begin
      $display("timeout: %0d results of %s never came out", exp_q.size(), name);
      $display("TEST FAIL");
      $finish;
    end else begin
      $display("%s: %0d results, %0d errors", name, test_checks, test_errors);
      tests++;
      total_checks += test_checks;
      total_errors += test_errors;
      test_checks = 0;
      test_errors = 0;
    end
  endtask

  initial begin
    logic [15:0] bv;
    clk = 1'b0;
    reset = 1'b1;
    // an instruction offered during reset must never come out
    in_valid = 1'b1;
    ic_bytes = '0;
    byte_valids = '0;
    eip = '0;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    in_valid = 1'b0;
    // out_valid must stay low while idle
    repeat (4) @(posedge clk);
    #1;
    send_inst(0, 0, 8'h90, 0, 0);
    finish_test("reset");

    send_inst(0, 0, 8'h90, 0, 0);
    send_inst(1, 32'hF2, 8'h05, 0, 0);
    send_inst(2, 32'h2E66, 8'hB8, 0, 0);
    send_inst(3, 32'hF2360F, 8'h04, 0, 0);
    send_inst(4, 32'h3E656426, 8'h89, 1, 96'hC0);
    // several segment overrides
    send_inst(3, 32'h2E3665, 8'h90, 0, 0);
    send_inst(2, 32'h263E, 8'h90, 0, 0);
    send_inst(4, 32'h65643665, 8'hC3, 0, 0);
    // byte 4 falls to the opcode
    send_inst(4, 32'h362E66F2, 8'h66, 0, 0);
    send_inst(4, 32'h0F0F0F0F, 8'h26, 0, 0);
    finish_test("prefixes");

    for (int s = 0; s < 2; s++) begin
      send_inst(s, 32'h66, 8'h90, 0, 0);
      send_inst(s, 32'h66, 8'h05, 0, 0);
      send_inst(s, 32'h66, 8'hBC, 0, 0);
      send_inst(s, 32'h66, 8'hE9, 0, 0);
      send_inst(s, 32'h66, 8'h89, 1, 96'hC1);
      send_inst(s, 32'h66, 8'h83, 2, 96'hF0C1);
      send_inst(s, 32'h66, 8'h81, 1, 96'hC1);
      send_inst(s, 32'h66, 8'hC7, 1, 96'h05);
    end
    send_inst(0, 0, 8'h8B, 1, 96'h08);
    send_inst(0, 0, 8'h8B, 1, 96'h0D);
    send_inst(0, 0, 8'h8B, 2, 96'h804B);
    send_inst(0, 0, 8'h8B, 2, 96'h7F4B);
    send_inst(0, 0, 8'h8B, 1, 96'h93);
    send_inst(0, 0, 8'h8B, 1, 96'hD8);
    // SIB base 101 under mod 00 brings a disp32
    send_inst(0, 0, 8'h8B, 2, 96'h250C);
    send_inst(0, 0, 8'h8B, 2, 96'h180C);
    send_inst(0, 0, 8'h8B, 3, 96'hFE254C);
    send_inst(1, 32'h66, 8'h83, 4, 96'h85902444);
    send_inst(0, 0, 8'h04, 1, 96'h80);
    send_inst(0, 0, 8'h04, 1, 96'h7F);
    send_inst(0, 0, 8'h6A, 1, 96'hFF);
    send_inst(0, 0, 8'h00, 0, 0);
    send_inst(1, 32'h2E, 8'hFF, 0, 0);
    send_inst(0, 0, 8'h8D, 1, 96'h05);
    send_inst(0, 0, 8'hD4, 0, 0);
    finish_test("fields and length");

    send(make_window(0, 0, 8'hF4, 0, 0), 16'hFFFF, 32'hFFFFFFFF);
    send(make_window(0, 0, 8'hE8, 0, 0), 16'hFFFF, 32'hFFFFFFFD);
    send(make_window(1, 32'h66, 8'hB8, 0, 0), 16'hFFFF, 32'hFFFFFFFC);
    send_inst(0, 0, 8'hCF, 0, 0);
    send_inst(2, 32'h3E66, 8'hCF, 0, 0);
    send_inst(1, 32'hF2, 8'hF4, 0, 0);
    send_inst(0, 0, 8'hC3, 0, 0);
    finish_test("next eip and specials");

    send(make_window(0, 0, 8'h05, 0, 0), 16'h001F, rand_bits(32));
    send(make_window(0, 0, 8'h05, 0, 0), 16'h000F, rand_bits(32));
    send(make_window(0, 0, 8'h05, 0, 0), 16'hFFEF, rand_bits(32));
    send(make_window(0, 0, 8'h05, 0, 0), 16'h0000, rand_bits(32));
    send(make_window(0, 0, 8'h90, 0, 0), 16'h0001, rand_bits(32));
    // 15-byte instruction at both edges of its length
    send(make_window(4, 32'h3E2EF20F, 8'hC7, 10, 96'h0000_89ABCDEF_12345678_0084),
         16'h7FFF, rand_bits(32));
    send(make_window(4, 32'h3E2EF20F, 8'hC7, 10, 96'h0000_89ABCDEF_12345678_0084),
         16'h3FFF, rand_bits(32));
    finish_test("fetch exception");

    for (int k = 0; k < 24; k++) begin
      bv = 16'hFFFF;
      if (rand_bits(2) == 0) bv[rand_bits(4)] = 1'b0;
      send(rand_window(), bv, rand_bits(32));
    end
    finish_test("streaming");

    $display("%0d tests, %0d results checked, %0d errors", tests, total_checks, total_errors);
    if (total_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+test
hdl/decode_pkg.sv
hdl/decode_ifs.sv
hdl/prefix_byte_classify.sv
hdl/prefix_merge.sv
hdl/opcode_attr_rom.sv
hdl/field_extract.sv
hdl/decode_result_stage.sv
hdl/decode_top.sv
test/tb_decode_top.sv
